// File: exeStage.f
+incdir+.
exuOpsPkg.sv
exuStagePkg.sv
operandBypass.sv
integerAlu.sv
hiLoUnit.sv
exeControl.sv
exeStage.sv
exeStageTb.sv

// File: exeStageTbTable.svh
task automatic fillTable();
    // Name, op, regA, A, regB, B, writeReg, {regWrite memRead memWrite}, expected aluResult
    // Independent arithmetic and logic
    addRow("add", exuOpsPkg::opAdd, 1, 'h5, 2, 'h7, 3, 3'b100, 'hC);
    addRow("sub", exuOpsPkg::opSub, 4, 'h3, 5, 'h5, 6, 3'b100, 'hFFFFFFFE);
    addRow("and", exuOpsPkg::opAnd, 7, 'hF0F01234, 8, 'h0FF0FF00, 9, 3'b100, 'h00F01200);
    addRow("or", exuOpsPkg::opOr, 10, 'hF000000F, 11, 'h0000F0F0, 12, 3'b100, 'hF000F0FF);
    addRow("xor", exuOpsPkg::opXor, 13, 'hFFFF0000, 14, 'h0F0F0F0F, 15, 3'b100,
        'hF0F00F0F);
    addRow("nor", exuOpsPkg::opNor, 16, 'h000000FF, 17, 'h00FF0000, 18, 3'b100,
        'hFF00FF00);
    // Same operands, signed then unsigned compare
    addRow("slt signed", exuOpsPkg::opSlt, 19, 'hFFFFFFFF, 20, 'h1, 21, 3'b100, 'h1);
    addRow("sltu unsigned", exuOpsPkg::opSltu, 19, 'hFFFFFFFF, 20, 'h1, 22, 3'b100, 'h0);
    addRow("lui", exuOpsPkg::opLui, 0, 'h0, 23, 'h0000ABCD, 24, 3'b100, 'hABCD0000);
    // Shifts
    addRow("sll fixed", exuOpsPkg::opSll, 0, 'h0, 25, 'h1, 26, 3'b100, 'h80000000);
    shiftBy(5'd31);
    addRow("srl fixed", exuOpsPkg::opSrl, 0, 'h0, 27, 'h80000000, 28, 3'b100, 'h08000000);
    shiftBy(5'd4);
    addRow("sra fixed", exuOpsPkg::opSra, 0, 'h0, 29, 'h80000000, 30, 3'b100, 'hF8000000);
    shiftBy(5'd4);
    // Only the low five bits of A count as the amount
    addRow("sllv", exuOpsPkg::opSllv, 5, 'h23, 6, 'h1, 4, 3'b100, 'h8);
    addRow("srav negative", exuOpsPkg::opSrav, 1, 'h24, 2, 'hF0000000, 3, 3'b100,
        'hFF000000);
    addRow("srlv", exuOpsPkg::opSrlv, 7, 'h1F, 8, 'h80000000, 9, 3'b100, 'h1);
    // Forwarding, stale decode values must be replaced
    addRow("fwd back to back", exuOpsPkg::opAdd, 9, 'hDEAD, 10, 'h10, 11, 3'b100, 'h11);
    addRow("fwd own over mem", exuOpsPkg::opAdd, 11, 'h0, 12, 'h100, 13, 3'b100, 'h111);
    forwardFromMem(5'd11, 'h5555);
    addRow("fwd mem only", exuOpsPkg::opOr, 14, 'h0, 15, 'h10000000, 16, 3'b100,
        'h10000F0F);
    forwardFromMem(5'd14, 'h0F0F);
    addRow("r0 mem source", exuOpsPkg::opAdd, 0, 'h0, 17, 'h22, 0, 3'b100, 'h22);
    forwardFromMem(5'd0, 'hBAD0BAD0);
    addRow("r0 own source", exuOpsPkg::opAdd, 0, 'h3, 19, 'h4, 20, 3'b100, 'h7);
    addRow("load address", exuOpsPkg::opAdd, 21, 'h1000, 0, 'h40, 22, 3'b110, 'h1040);
    addRow("load not fwd", exuOpsPkg::opAdd, 22, 'h1, 23, 'h1, 24, 3'b100, 'h2);
    addRow("store data fwd", exuOpsPkg::opAdd, 25, 'h2000, 0, 'h8, 24, 3'b001, 'h2008);
    storeOperand('hDEAD, 'h2);
    // Multiply and HI/LO moves
    addRow("mult", exuOpsPkg::opMult, 1, 'hFFFFFFFE, 2, 'h3, 0, 3'b000, 'h0);
    addRow("mfhi signed", exuOpsPkg::opMfhi, 0, 'h0, 0, 'h0, 3, 3'b100, 'hFFFFFFFF);
    addRow("mflo signed", exuOpsPkg::opMflo, 0, 'h0, 0, 'h0, 4, 3'b100, 'hFFFFFFFA);
    addRow("multu", exuOpsPkg::opMultu, 5, 'hFFFFFFFE, 6, 'h3, 0, 3'b000, 'h0);
    addRow("mfhi unsigned", exuOpsPkg::opMfhi, 0, 'h0, 0, 'h0, 7, 3'b100, 'h2);
    addRow("mthi", exuOpsPkg::opMthi, 8, 'h12345678, 0, 'h0, 0, 3'b000, 'h0);
    addRow("mtlo", exuOpsPkg::opMtlo, 9, 'h9ABCDEF0, 0, 'h0, 0, 3'b000, 'h0);
    addRow("mfhi after mthi", exuOpsPkg::opMfhi, 0, 'h0, 0, 'h0, 10, 3'b100, 'h12345678);
    addRow("mflo after mtlo", exuOpsPkg::opMflo, 0, 'h0, 0, 'h0, 11, 3'b100, 'h9ABCDEF0);
    // Flushed multiply, HI/LO must keep the moved values
    addRow("flush mult", exuOpsPkg::opMult, 12, 'h10, 13, 'h10, 14, 3'b100, 'h0);
    flushSlot();
    addRow("hi after flush", exuOpsPkg::opMfhi, 0, 'h0, 0, 'h0, 15, 3'b100, 'h12345678);
    addRow("lo after flush", exuOpsPkg::opMflo, 0, 'h0, 0, 'h0, 16, 3'b100, 'h9ABCDEF0);
    addRow("pass b", exuOpsPkg::opPassB, 0, 'h0, 17, 'h0BADF00D, 18, 3'b100, 'h0BADF00D);
endtask

// File: exeStageTb.sv
module exeStageTb;
    timeunit 1ns;
    timeprecision 1ps;

    logic                  CLK;
    logic                  RESET;
    logic                  flush;
    exuStagePkg::exeInT    exeIn;
    exuStagePkg::bypassT   memBypass;
    exuStagePkg::memStageT exeOut;
    exuStagePkg::bypassT   earlyBypass;

    // Stimulus table, one entry per row
    string                 rowName[$];
    exuStagePkg::exeInT    rowIn[$];
    exuStagePkg::bypassT   rowMem[$];
    logic                  rowFlush[$];
    logic [31:0]           rowResult[$];
    logic [31:0]           rowStore[$];

    integer seed;
    int     rowOk;
    int     passCount;
    int     failCount;
    int     cycleCount;
    int     cycleLimit;

    exeStage u_dut (
        .CLK         (CLK),
        .RESET       (RESET),
        .flush       (flush),
        .exeIn       (exeIn),
        .memBypass   (memBypass),
        .exeOut      (exeOut),
        .earlyBypass (earlyBypass)
    );

    `include "exeStageTbTable.svh"

    //////////////////////////////////////////////////
    // Table building
    //////////////////////////////////////////////////

    task automatic addRow(input string name, input exuOpsPkg::aluOpT op, input int regA,
                          input logic [31:0] a, input int regB, input logic [31:0] b,
                          input int dst, input logic [2:0] ctl, input logic [31:0] result);
        exuStagePkg::exeInT rec;
        rec = '0;
        rec.aluOp    = op;
        rec.regA     = regA[4:0];
        rec.operandA = a;
        rec.regB     = regB[4:0];
        rec.operandB = b;
        rec.writeReg = dst[4:0];
        {rec.regWrite, rec.memRead, rec.memWrite} = ctl;
        // Pass-through fields are random, only their transport matters
        rec.instr        = $random(seed);
        rec.pc           = $random(seed);
        rec.altPc        = $random(seed);
        rec.requestAltPc = $random(seed);
        rec.predTaken    = $random(seed);
        rec.predAddr     = $random(seed);
        rec.predHistory  = $random(seed);
        rowName.push_back(name);
        rowIn.push_back(rec);
        rowMem.push_back('0);
        rowFlush.push_back(1'b0);
        rowResult.push_back(result);
        rowStore.push_back('0);
    endtask

    // Row modifiers, each acts on the last row added
    task automatic shiftBy(input logic [4:0] amount);
        exuStagePkg::exeInT rec;
        rec = rowIn[rowIn.size()-1];
        rec.shiftAmount = amount;
        rowIn[rowIn.size()-1] = rec;
    endtask

    task automatic forwardFromMem(input logic [4:0] regAddr, input logic [31:0] data);
        exuStagePkg::bypassT src;
        src.regAddr = regAddr;
        src.data    = data;
        src.valid   = 1'b1;
        rowMem[rowMem.size()-1] = src;
    endtask

    task automatic storeOperand(input logic [31:0] decoded, input logic [31:0] expected);
        exuStagePkg::exeInT rec;
        rec = rowIn[rowIn.size()-1];
        rec.storeData = decoded;
        rowIn[rowIn.size()-1] = rec;
        rowStore[rowStore.size()-1] = expected;
    endtask

    task automatic flushSlot();
        rowFlush[rowFlush.size()-1] = 1'b1;
    endtask

    //////////////////////////////////////////////////
    // Checking and row execution
    //////////////////////////////////////////////////

    task automatic compareValue(input string sigName, input logic [255:0] got,
                                input logic [255:0] expected);
        if (got !== expected) begin
            $display("error: %s got 0x%0h expected 0x%0h", sigName, got, expected);
            rowOk = 0;
        end
    endtask

    task automatic runRow(input int idx);
        exuStagePkg::exeInT    rec;
        exuStagePkg::memStageT expOut;
        exuStagePkg::bypassT   expEarly;
        rec   = rowIn[idx];
        rowOk = 1;
        @(negedge CLK);
        exeIn     = rec;
        memBypass = rowMem[idx];
        flush     = rowFlush[idx];
        #2;
        // Same-cycle result, valid only for a register write with no memory access
        if (!rowFlush[idx]) begin
            expEarly.regAddr = rec.writeReg;
            expEarly.data    = rowResult[idx];
            expEarly.valid   = rec.regWrite && !(rec.memRead || rec.memWrite);
            compareValue("earlyBypass", earlyBypass, expEarly);
        end
        @(posedge CLK);
        #2;
        // A flushed slot leaves an all-zero record
        expOut = '0;
        if (!rowFlush[idx]) begin
            expOut.instr        = rec.instr;
            expOut.pc           = rec.pc;
            expOut.aluResult    = rowResult[idx];
            expOut.writeReg     = rec.writeReg;
            expOut.storeData    = rowStore[idx];
            expOut.regWrite     = rec.regWrite;
            expOut.memRead      = rec.memRead;
            expOut.memWrite     = rec.memWrite;
            expOut.aluOp        = rec.aluOp;
            expOut.altPc        = rec.altPc;
            expOut.requestAltPc = rec.requestAltPc;
            expOut.predTaken    = rec.predTaken;
            expOut.predAddr     = rec.predAddr;
            expOut.predHistory  = rec.predHistory;
        end
        compareValue("exeOut.aluResult", exeOut.aluResult, expOut.aluResult);
        compareValue("exeOut.storeData", exeOut.storeData, expOut.storeData);
        compareValue("exeOut", exeOut, expOut);
        if (rowOk) begin
            passCount++;
            $display("%-18s ok", rowName[idx]);
        end else begin
            failCount++;
            $display("%-18s mismatch", rowName[idx]);
        end
    endtask

    //////////////////////////////////////////////////
    // Clock, timeout and main sequence
    //////////////////////////////////////////////////

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    // Run limit covers reset, every row and some slack
    always @(posedge CLK) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            $display("timeout, run still going after %0d cycles", cycleLimit);
            $display("TB FAILED");
            $finish;
        end
    end

    initial begin
        seed       = 88;
        passCount  = 0;
        failCount  = 0;
        cycleCount = 0;
        RESET      = 1'b0;
        flush      = 1'b0;
        exeIn      = '0;
        memBypass  = '0;
        fillTable();
        cycleLimit = rowName.size() + 8 + 20;
        repeat (8) @(negedge CLK);
        RESET = 1'b1;
        for (int i = 0; i < rowName.size(); i++) begin
            runRow(i);
        end
        $display("tests %0d, passed %0d, failed %0d", rowName.size(), passCount, failCount);
        if (failCount == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: exeStage.sv
module exeStage (
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  flush,
    input  exuStagePkg::exeInT    exeIn,
    input  exuStagePkg::bypassT   memBypass,
    output exuStagePkg::memStageT exeOut,
    output exuStagePkg::bypassT   earlyBypass
);

    // Operands after forwarding
    logic [exuOpsPkg::dataWidth-1:0] operandA;
    logic [exuOpsPkg::dataWidth-1:0] operandB;
    logic [exuOpsPkg::dataWidth-1:0] storeData;

    logic [exuOpsPkg::dataWidth-1:0] aluResult;
    logic [exuOpsPkg::dataWidth-1:0] hi;
    logic [exuOpsPkg::dataWidth-1:0] lo;

    exuOpsPkg::hiLoWriteT            hiLoWrite;
    logic                            hiLoUpdate;
    logic                            signedMul;
    exuStagePkg::bypassT             ownBypass;

    //////////////////////////////////////////////////
    // Forwarding, own result over memory stage
    //////////////////////////////////////////////////

    operandBypass u_bypassA (
        .readReg   (exeIn.regA),
        .decoded   (exeIn.operandA),
        .firstSrc  (ownBypass),
        .secondSrc (memBypass),
        .value     (operandA)
    );

    operandBypass u_bypassB (
        .readReg   (exeIn.regB),
        .decoded   (exeIn.operandB),
        .firstSrc  (ownBypass),
        .secondSrc (memBypass),
        .value     (operandB)
    );

    // Store data is read through the destination index
    operandBypass u_bypassStore (
        .readReg   (exeIn.writeReg),
        .decoded   (exeIn.storeData),
        .firstSrc  (ownBypass),
        .secondSrc (memBypass),
        .value     (storeData)
    );

    //////////////////////////////////////////////////
    // Datapath
    //////////////////////////////////////////////////

    integerAlu u_alu (
        .operandA    (operandA),
        .operandB    (operandB),
        .shiftAmount (exeIn.shiftAmount),
        .aluOp       (exeIn.aluOp),
        .hi          (hi),
        .lo          (lo),
        .result      (aluResult)
    );

    hiLoUnit u_hiLo (
        .CLK       (CLK),
        .RESET     (RESET),
        .update    (hiLoUpdate),
        .hiLoWrite (hiLoWrite),
        .operandA  (operandA),
        .operandB  (operandB),
        .signedMul (signedMul),
        .hi        (hi),
        .lo        (lo)
    );

    // Pipeline register and stage control
    exeControl u_control (
        .CLK         (CLK),
        .RESET       (RESET),
        .flush       (flush),
        .exeIn       (exeIn),
        .storeData   (storeData),
        .aluResult   (aluResult),
        .hiLoWrite   (hiLoWrite),
        .hiLoUpdate  (hiLoUpdate),
        .signedMul   (signedMul),
        .ownBypass   (ownBypass),
        .earlyBypass (earlyBypass),
        .exeOut      (exeOut)
    );

endmodule

// File: exeControl.sv
module exeControl (
    input  logic                            CLK,
    input  logic                            RESET,
    input  logic                            flush,
    input  exuStagePkg::exeInT              exeIn,
    input  logic [exuOpsPkg::dataWidth-1:0] storeData,
    input  logic [exuOpsPkg::dataWidth-1:0] aluResult,
    output exuOpsPkg::hiLoWriteT            hiLoWrite,
    output logic                            hiLoUpdate,
    output logic                            signedMul,
    output exuStagePkg::bypassT             ownBypass,
    output exuStagePkg::bypassT             earlyBypass,
    output exuStagePkg::memStageT           exeOut
);

    exuStagePkg::memStageT nextOut;

    //////////////////////////////////////////////////
    // HI/LO control decode
    //////////////////////////////////////////////////

    always_comb begin
        case (exeIn.aluOp)
            exuOpsPkg::opMult,
            exuOpsPkg::opMultu: hiLoWrite = exuOpsPkg::hlBoth;
            exuOpsPkg::opMthi:  hiLoWrite = exuOpsPkg::hlHiOnly;
            exuOpsPkg::opMtlo:  hiLoWrite = exuOpsPkg::hlLoOnly;
            default:            hiLoWrite = exuOpsPkg::hlNone;
        endcase
    end

    // Only mult is signed, multu and moves ignore this
    assign signedMul = (exeIn.aluOp == exuOpsPkg::opMult);

    // A flushed slot must not commit to HI/LO
    assign hiLoUpdate = !flush;

    //////////////////////////////////////////////////
    // Bypass records
    //////////////////////////////////////////////////

    // Registered result, loads and stores have no value yet
    assign ownBypass.regAddr = exeOut.writeReg;
    assign ownBypass.data    = exeOut.aluResult;
    assign ownBypass.valid   = exeOut.regWrite && !(exeOut.memRead || exeOut.memWrite);

    // Same-cycle result for decode stage forwarding
    assign earlyBypass.regAddr = exeIn.writeReg;
    assign earlyBypass.data    = aluResult;
    assign earlyBypass.valid   = exeIn.regWrite && !(exeIn.memRead || exeIn.memWrite);

    //////////////////////////////////////////////////
    // Memory stage record
    //////////////////////////////////////////////////

    always_comb begin
        nextOut.instr        = exeIn.instr;
        nextOut.pc           = exeIn.pc;
        nextOut.aluResult    = aluResult;
        nextOut.writeReg     = exeIn.writeReg;
        // Forwarded value, not the decode copy
        nextOut.storeData    = storeData;
        nextOut.regWrite     = exeIn.regWrite;
        nextOut.memRead      = exeIn.memRead;
        nextOut.memWrite     = exeIn.memWrite;
        nextOut.aluOp        = exeIn.aluOp;
        // Redirect and prediction fields ride along unchanged
        nextOut.altPc        = exeIn.altPc;
        nextOut.requestAltPc = exeIn.requestAltPc;
        nextOut.predTaken    = exeIn.predTaken;
        nextOut.predAddr     = exeIn.predAddr;
        nextOut.predHistory  = exeIn.predHistory;
    end

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            exeOut <= '0;
        end else if (flush) begin
            // Flush turns the slot into a bubble
            exeOut <= '0;
        end else begin
            exeOut <= nextOut;
        end
    end

endmodule

// File: hiLoUnit.sv
module hiLoUnit (
    input  logic                            CLK,
    input  logic                            RESET,
    input  logic                            update,
    input  exuOpsPkg::hiLoWriteT            hiLoWrite,
    input  logic [exuOpsPkg::dataWidth-1:0] operandA,
    input  logic [exuOpsPkg::dataWidth-1:0] operandB,
    input  logic                            signedMul,
    output logic [exuOpsPkg::dataWidth-1:0] hi,
    output logic [exuOpsPkg::dataWidth-1:0] lo
);

    localparam int extWidth = exuOpsPkg::dataWidth + 1;
    localparam int prodWidth = 2 * exuOpsPkg::dataWidth;

    logic signed [extWidth-1:0]   extA;
    logic signed [extWidth-1:0]   extB;
    logic signed [2*extWidth-1:0] fullProduct;
    logic [prodWidth-1:0]         product;

    //////////////////////////////////////////////////
    // Multiplier
    //////////////////////////////////////////////////

    // One extra bit turns both signed and unsigned into a signed multiply
    assign extA = {signedMul & operandA[exuOpsPkg::dataWidth-1], operandA};
    assign extB = {signedMul & operandB[exuOpsPkg::dataWidth-1], operandB};

    assign fullProduct = extA * extB;
    // Low 64 bits are exact for either signedness
    assign product = fullProduct[prodWidth-1:0];

    //////////////////////////////////////////////////
    // HI/LO registers
    //////////////////////////////////////////////////

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            hi <= '0;
            lo <= '0;
        end else if (update) begin
            case (hiLoWrite)
                exuOpsPkg::hlBoth: begin
                    // Upper product half to HI
                    hi <= product[prodWidth-1:exuOpsPkg::dataWidth];
                    lo <= product[exuOpsPkg::dataWidth-1:0];
                end
                exuOpsPkg::hlHiOnly: hi <= operandA;
                exuOpsPkg::hlLoOnly: lo <= operandA;
                default: begin
                    // Other ops leave both untouched
                    hi <= hi;
                    lo <= lo;
                end
            endcase
        end
    end

endmodule

// File: integerAlu.sv
module integerAlu (
    input  logic [exuOpsPkg::dataWidth-1:0]  operandA,
    input  logic [exuOpsPkg::dataWidth-1:0]  operandB,
    input  logic [exuOpsPkg::shamtWidth-1:0] shiftAmount,
    input  exuOpsPkg::aluOpT                 aluOp,
    input  logic [exuOpsPkg::dataWidth-1:0]  hi,
    input  logic [exuOpsPkg::dataWidth-1:0]  lo,
    output logic [exuOpsPkg::dataWidth-1:0]  result
);

    localparam int halfWidth = exuOpsPkg::dataWidth / 2;

    logic [exuOpsPkg::shamtWidth-1:0] varAmount;
    logic                             signedLess;
    logic                             unsignedLess;

    // Register shifts use the low bits of A
    assign varAmount = operandA[exuOpsPkg::shamtWidth-1:0];

    // Compare results, zero extended below
    assign signedLess   = $signed(operandA) < $signed(operandB);
    assign unsignedLess = operandA < operandB;

    //////////////////////////////////////////////////
    // Operation select
    //////////////////////////////////////////////////

    always_comb begin
        unique case (aluOp)
            exuOpsPkg::opAdd:   result = operandA + operandB;
            exuOpsPkg::opSub:   result = operandA - operandB;
            exuOpsPkg::opAnd:   result = operandA & operandB;
            exuOpsPkg::opOr:    result = operandA | operandB;
            exuOpsPkg::opXor:   result = operandA ^ operandB;
            exuOpsPkg::opNor:   result = ~(operandA | operandB);
            exuOpsPkg::opSlt:   result = {{(exuOpsPkg::dataWidth-1){1'b0}}, signedLess};
            exuOpsPkg::opSltu:  result = {{(exuOpsPkg::dataWidth-1){1'b0}}, unsignedLess};
            // Immediate sits in the low half of B
            exuOpsPkg::opLui:   result = {operandB[halfWidth-1:0], {halfWidth{1'b0}}};

            // Fixed shifts, amount from the instruction
            exuOpsPkg::opSll:   result = operandB << shiftAmount;
            exuOpsPkg::opSrl:   result = operandB >> shiftAmount;
            exuOpsPkg::opSra:   result = $signed(operandB) >>> shiftAmount;

            // Variable shifts, amount from A
            exuOpsPkg::opSllv:  result = operandB << varAmount;
            exuOpsPkg::opSrlv:  result = operandB >> varAmount;
            exuOpsPkg::opSrav:  result = $signed(operandB) >>> varAmount;

            // Reads of the special registers
            exuOpsPkg::opMfhi:  result = hi;
            exuOpsPkg::opMflo:  result = lo;

            exuOpsPkg::opPassB: result = operandB;

            // Multiply and move-to only touch HI/LO
            exuOpsPkg::opMult,
            exuOpsPkg::opMultu,
            exuOpsPkg::opMthi,
            exuOpsPkg::opMtlo:  result = '0;

            default:            result = '0;
        endcase
    end

endmodule

// File: operandBypass.sv
module operandBypass (
    input  logic [exuOpsPkg::regAddrWidth-1:0] readReg,
    input  logic [exuOpsPkg::dataWidth-1:0]    decoded,
    input  exuStagePkg::bypassT                firstSrc,
    input  exuStagePkg::bypassT                secondSrc,
    output logic [exuOpsPkg::dataWidth-1:0]    value
);

    logic readsZero;
    logic firstHit;
    logic secondHit;

    // Register zero is hardwired, never take a forwarded value for it
    assign readsZero = (readReg == '0);

    // Source matches on valid plus equal index
    assign firstHit  = firstSrc.valid && (firstSrc.regAddr == readReg);
    assign secondHit = secondSrc.valid && (secondSrc.regAddr == readReg);

    //////////////////////////////////////////////////
    // Priority select
    //////////////////////////////////////////////////

    always_comb begin
        // Decode value unless a younger result exists
        value = decoded;
        if (!readsZero) begin
            if (firstHit) begin
                // Newest result, one stage ahead
                value = firstSrc.data;
            end else if (secondHit) begin
                // Older result leaving memory stage
                value = secondSrc.data;
            end
        end
    end

endmodule

// File: exuStagePkg.sv
package exuStagePkg;

    //////////////////////////////////////////////////
    // Decode to execute record
    //////////////////////////////////////////////////

    typedef struct packed {
        // Instruction word and its PC, carried for debug
        logic [exuOpsPkg::dataWidth-1:0]    instr;
        logic [exuOpsPkg::dataWidth-1:0]    pc;
        // Source A index and the value read in decode
        logic [exuOpsPkg::regAddrWidth-1:0] regA;
        logic [exuOpsPkg::dataWidth-1:0]    operandA;
        // Source B index and the value read in decode
        logic [exuOpsPkg::regAddrWidth-1:0] regB;
        logic [exuOpsPkg::dataWidth-1:0]    operandB;
        // Destination, also the store source register
        logic [exuOpsPkg::regAddrWidth-1:0] writeReg;
        logic [exuOpsPkg::dataWidth-1:0]    storeData;
        // Controls, all zero in a bubble
        logic                               regWrite;
        logic                               memRead;
        logic                               memWrite;
        exuOpsPkg::aluOpT                   aluOp;
        logic [exuOpsPkg::shamtWidth-1:0]   shiftAmount;
        // Redirect and branch prediction, passed through
        logic [exuOpsPkg::dataWidth-1:0]    altPc;
        logic                               requestAltPc;
        logic                               predTaken;
        logic [exuOpsPkg::dataWidth-1:0]    predAddr;
        logic [1:0]                         predHistory;
    } exeInT;

    //////////////////////////////////////////////////
    // Execute to memory record
    //////////////////////////////////////////////////

    typedef struct packed {
        logic [exuOpsPkg::dataWidth-1:0]    instr;
        logic [exuOpsPkg::dataWidth-1:0]    pc;
        // Address for loads and stores, result otherwise
        logic [exuOpsPkg::dataWidth-1:0]    aluResult;
        logic [exuOpsPkg::regAddrWidth-1:0] writeReg;
        // Store data after forwarding
        logic [exuOpsPkg::dataWidth-1:0]    storeData;
        logic                               regWrite;
        logic                               memRead;
        logic                               memWrite;
        // Memory stage reads the op to pick access size
        exuOpsPkg::aluOpT                   aluOp;
        logic [exuOpsPkg::dataWidth-1:0]    altPc;
        logic                               requestAltPc;
        logic                               predTaken;
        logic [exuOpsPkg::dataWidth-1:0]    predAddr;
        logic [1:0]                         predHistory;
    } memStageT;

    // One forwarding source
    typedef struct packed {
        logic [exuOpsPkg::regAddrWidth-1:0] regAddr;
        logic [exuOpsPkg::dataWidth-1:0]    data;
        logic                               valid;
    } bypassT;

endpackage

// File: exuOpsPkg.sv
package exuOpsPkg;

    //////////////////////////////////////////////////
    // Datapath widths
    //////////////////////////////////////////////////

    // Integer data word
    localparam int dataWidth = 32;
    // Register file index
    localparam int regAddrWidth = 5;
    // Immediate shift amount field
    localparam int shamtWidth = 5;

    //////////////////////////////////////////////////
    // ALU operation codes
    //////////////////////////////////////////////////

    // Code zero is add, so a bubble record decodes as a harmless add
    typedef enum logic [5:0] {
        opAdd   = 6'h00,
        opSub   = 6'h01,
        opAnd   = 6'h02,
        opOr    = 6'h03,
        opXor   = 6'h04,
        opNor   = 6'h05,
        opSlt   = 6'h06,
        opSltu  = 6'h07,
        opLui   = 6'h08,
        // Shifts, fixed amount then register amount
        opSll   = 6'h10,
        opSrl   = 6'h11,
        opSra   = 6'h12,
        opSllv  = 6'h13,
        opSrlv  = 6'h14,
        opSrav  = 6'h15,
        // Multiply and HI/LO moves
        opMult  = 6'h20,
        opMultu = 6'h21,
        opMfhi  = 6'h22,
        opMflo  = 6'h23,
        opMthi  = 6'h24,
        opMtlo  = 6'h25,
        // Operand B straight through
        opPassB = 6'h30
    } aluOpT;

    // HI/LO write selection
    typedef enum logic [1:0] {
        hlNone   = 2'b00,
        hlBoth   = 2'b01,
        hlHiOnly = 2'b10,
        hlLoOnly = 2'b11
    } hiLoWriteT;

endpackage
